// ==== Makefile ====
# Verilator flow for the bus-cycle core and its testbench
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Fails unless the pass message appears on a line of its own
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/cpuTb.sv ====
//----------------------------------------------------------
// Directed tests for the bus-cycle core. Inputs are driven
// on the falling edge, bus activity is captured there too.
// Waits poll on the rising edge with a cycle budget each.
//----------------------------------------------------------
`timescale 1ns/1ps

module cpuTb;

  localparam int halfPeriod  = 50;
  localparam int resetCycles = 8;
  localparam int ldOutBudget = 80;
  localparam int jumpBudget  = 40;
  localparam int rfshBudget  = 600;
  localparam int haltBudget  = 100;
  localparam int watchdogCycles = 6 * (resetCycles + 2) + 2 * ldOutBudget + jumpBudget
                                  + rfshBudget + haltBudget + 200;

  // Event kinds polled by waitEvents
  localparam int evFetch   = 0;
  localparam int evRefresh = 1;
  localparam int evHalt    = 2;
  localparam int evGrant   = 3;
  localparam int evRelease = 4;

  logic         clk, reset_n, waitN, busRqN;
  cpuPkg::dataT dataIn, dataOut;
  cpuPkg::addrT addr;
  logic         m1N, rfshN, rd, wr, iorq, haltN, busAkN;
  int           readWaits;

  logic [31:0]  rngState;
  int           errCount, passCount, failCount;

  // Bus activity seen by the monitor
  cpuPkg::addrT fetchAddr[$];
  int           fetchCyc[$];
  cpuPkg::addrT rfshAddr[$];
  logic         rfshHighBits;
  int           cycleNo;
  logic         prevM1N, prevRfshN, haltS, busAkS;

  cpuTop cpuTop_i (
    .clk     (clk),
    .reset_n (reset_n),
    .waitN   (waitN),
    .busRqN  (busRqN),
    .dataIn  (dataIn),
    .addr    (addr),
    .dataOut (dataOut),
    .m1N     (m1N),
    .rfshN   (rfshN),
    .rd      (rd),
    .wr      (wr),
    .iorq    (iorq),
    .haltN   (haltN),
    .busAkN  (busAkN)
  );

  memModel memModel_i (
    .clk       (clk),
    .addr      (addr),
    .dataOut   (dataOut),
    .m1N       (m1N),
    .rd        (rd),
    .wr        (wr),
    .iorq      (iorq),
    .readWaits (readWaits),
    .dataIn    (dataIn),
    .waitN     (waitN)
  );

  always #(halfPeriod) clk = !clk;

  initial
  begin
    prevM1N      = 1'b1;
    prevRfshN    = 1'b1;
    haltS        = 1'b1;
    busAkS       = 1'b1;
    cycleNo      = 0;
    rfshHighBits = 1'b0;
  end

  always @(negedge clk)
  begin
    cycleNo = cycleNo + 1;
    if (!m1N && prevM1N)            // T1 of a fetch
    begin
      fetchAddr.push_back(addr);
      fetchCyc.push_back(cycleNo);
    end
    if (!rfshN && prevRfshN)
      rfshAddr.push_back(addr);
    if (!rfshN && (addr >> 7) != '0)
      rfshHighBits = 1'b1;
    prevM1N   = m1N;
    prevRfshN = rfshN;
    haltS     = haltN;
    busAkS    = busAkN;
  end

  //----------------------------------------------------------
  // Helpers
  //----------------------------------------------------------
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x        = rngState;
    x        = x ^ (x << 13);
    x        = x ^ (x >> 17);
    x        = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic int eventCount(input int kind);
    case (kind)
      evFetch:   return fetchAddr.size();
      evRefresh: return rfshAddr.size();
      evHalt:    return (haltS == 1'b0) ? 1 : 0;
      evGrant:   return (busAkS == 1'b0) ? 1 : 0;
      default:   return (busAkS == 1'b1) ? 1 : 0;
    endcase
  endfunction

  task automatic reportMismatch(input string msg);
    $display("error %0t: %s", $time, msg);
    errCount++;
  endtask

  task automatic reportProblem(input string msg);
    $display("%s", msg);
    errCount++;
  endtask

  task automatic waitEvents(input int kind, input int count, input int budget,
                            input string what);
    int waited;
    waited = 0;
    @(posedge clk);
    while (eventCount(kind) < count && waited < budget)
    begin
      @(posedge clk);
      waited++;
    end
    if (eventCount(kind) < count)
      reportProblem($sformatf("timed out after %0d cycles waiting for %s", budget, what));
  endtask

  task automatic resetDut();
    @(negedge clk);
    reset_n = 1'b0;
    busRqN  = 1'b1;
    repeat (resetCycles - 1) @(negedge clk);
    @(posedge clk);
    fetchAddr.delete();
    fetchCyc.delete();
    rfshAddr.delete();
    rfshHighBits = 1'b0;
    cycleNo      = 0;
    memModel_i.clearLog();
    @(negedge clk);
    reset_n = 1'b1;
  endtask

  task automatic checkFetch(input int idx, input cpuPkg::addrT expAddr, input int expGap);
    if (fetchAddr.size() <= idx)
      reportProblem($sformatf("fetch %0d never happened", idx));
    else
    begin
      if (fetchAddr[idx] !== expAddr)
        reportMismatch($sformatf("fetch %0d at %h, expected %h", idx, fetchAddr[idx], expAddr));
      if (expGap > 0 && fetchCyc[idx] - fetchCyc[idx - 1] != expGap)
        reportMismatch($sformatf("fetch %0d came %0d cycles after the previous, expected %0d",
                                 idx, fetchCyc[idx] - fetchCyc[idx - 1], expGap));
    end
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    if (errCount == errsBefore)
    begin
      passCount++;
      $display("%s: ok", name);
    end
    else
    begin
      failCount++;
      $display("%s: FAILED with %0d errors", name, errCount - errsBefore);
    end
  endtask

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------
  task automatic checkResetState();
    int errs;
    errs = errCount;
    memModel_i.clearAll();
    resetDut();
    // Still the last reset cycle here
    if (m1N !== 1'b1 || rfshN !== 1'b1 || rd !== 1'b0 || wr !== 1'b0 || iorq !== 1'b0
        || haltN !== 1'b1 || busAkN !== 1'b1)
      reportMismatch("control outputs active during reset");
    @(negedge clk);
    if (m1N !== 1'b0 || rd !== 1'b1 || rfshN !== 1'b1)
      reportMismatch($sformatf("first cycle is not fetch T1, m1N=%b rd=%b", m1N, rd));
    if (addr !== 16'h0000)
      reportMismatch($sformatf("first fetch at %h, expected 0000", addr));
    finishTest("reset state", errs);
  endtask

  // LD A,n then OUT (p),A, with k waits on each memory read
  task automatic ldOutTest(input int k);
    int           errs;
    cpuPkg::dataT n, p;
    errs = errCount;
    n    = 8'(nextRandom());
    p    = 8'(nextRandom());
    memModel_i.clearAll();
    memModel_i.loadByte(16'd0, cpuPkg::opLdAN);
    memModel_i.loadByte(16'd1, n);
    memModel_i.loadByte(16'd2, cpuPkg::opOut);
    memModel_i.loadByte(16'd3, p);
    memModel_i.loadByte(16'd4, cpuPkg::opJp);   // Park on JP 0004
    memModel_i.loadByte(16'd5, 8'h04);
    memModel_i.loadByte(16'd6, 8'h00);
    readWaits = k;
    resetDut();
    waitEvents(evFetch, 3, ldOutBudget, "the fetch after OUT");
    checkFetch(0, 16'd0, 0);
    checkFetch(1, 16'd2, 7 + k);
    checkFetch(2, 16'd4, 11 + k);
    if (memModel_i.ioCount != 1)
      reportProblem($sformatf("%0d I/O writes were logged instead of one", memModel_i.ioCount));
    else
    begin
      if (memModel_i.ioAddrLog[0] !== {n, p})
        reportMismatch($sformatf("I/O address %h, expected %h", memModel_i.ioAddrLog[0], {n, p}));
      if (memModel_i.ioDataLog[0] !== n)
        reportMismatch($sformatf("I/O data %h, expected %h", memModel_i.ioDataLog[0], n));
    end
    readWaits = 0;
    finishTest($sformatf("ld/out with %0d waits", k), errs);
  endtask

  task automatic jumpTest();
    int           errs;
    cpuPkg::addrT nn;
    errs = errCount;
    nn   = 16'(nextRandom()) | 16'h0100;    // Clear of the program
    memModel_i.clearAll();
    memModel_i.loadByte(16'd0, cpuPkg::opJp);
    memModel_i.loadByte(16'd1, nn[7:0]);
    memModel_i.loadByte(16'd2, nn[15:8]);
    resetDut();
    waitEvents(evFetch, 2, jumpBudget, "the fetch at the jump target");
    checkFetch(1, nn, 10);
    finishTest("jump", errs);
  endtask

  task automatic refreshTest();
    int           errs;
    logic         seenBad;
    cpuPkg::addrT expAddr;
    errs    = errCount;
    seenBad = 1'b0;
    memModel_i.clearAll();
    resetDut();
    waitEvents(evRefresh, 130, rfshBudget, "130 refresh cycles");
    for (int i = 1; i < rfshAddr.size(); i++)
    begin
      expAddr = (rfshAddr[i - 1] + 16'd1) & 16'h007F;
      if (!seenBad && rfshAddr[i] !== expAddr)
      begin
        reportMismatch($sformatf("refresh %0d at %h, expected %h", i, rfshAddr[i], expAddr));
        seenBad = 1'b1;
      end
    end
    if (rfshHighBits)
      reportMismatch("upper address bits set during refresh");
    finishTest("refresh", errs);
  endtask

  task automatic haltBusTest();
    int errs;
    int nBefore;
    errs = errCount;
    memModel_i.clearAll();
    memModel_i.loadByte(16'd0, cpuPkg::opHalt);
    resetDut();
    waitEvents(evHalt, 1, 20, "haltN low");
    waitEvents(evFetch, 3, 30, "repeated fetches in HALT");
    checkFetch(1, 16'd1, 4);
    checkFetch(2, 16'd1, 4);
    @(negedge clk);
    busRqN = 1'b0;
    waitEvents(evGrant, 1, 20, "busAkN low");
    repeat (3)
    begin
      @(negedge clk);
      if (rd !== 1'b0 || wr !== 1'b0 || iorq !== 1'b0 || m1N !== 1'b1 || rfshN !== 1'b1)
        reportMismatch("bus strobes active during bus grant");
      if (addr !== 16'h0000 || dataOut !== 8'h00)
        reportMismatch($sformatf("bus not parked, addr=%h dataOut=%h", addr, dataOut));
    end
    @(posedge clk);
    nBefore = fetchAddr.size();
    @(negedge clk);
    busRqN = 1'b1;
    waitEvents(evRelease, 1, 10, "busAkN high after release");
    waitEvents(evFetch, nBefore + 1, 20, "a fetch after bus release");
    checkFetch(nBefore, 16'd1, 0);
    if (haltS !== 1'b0)
      reportMismatch("haltN rose after bus release");
    finishTest("halt and bus grant", errs);
  endtask

  //----------------------------------------------------------
  // Sequence and summary
  //----------------------------------------------------------
  initial
  begin
    clk       = 1'b0;
    reset_n   = 1'b0;
    busRqN    = 1'b1;
    readWaits = 0;
    rngState  = 32'd92;
    errCount  = 0;
    passCount = 0;
    failCount = 0;
    checkResetState();
    ldOutTest(0);
    jumpTest();
    refreshTest();
    ldOutTest(1 + int'(nextRandom() % 32'd4));
    haltBusTest();
    $display("summary: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(2 * halfPeriod * watchdogCycles);
    $display("watchdog expired after %0d cycles, run stopped", watchdogCycles);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== dv/memModel.sv ====
//----------------------------------------------------------
// Memory and I/O model for the core testbench. Outputs
// change on the falling clock edge only. Wait states go to
// memory read cycles only, never to opcode fetches.
// The I/O log keeps the first 16 writes.
//----------------------------------------------------------
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memModel (
  input  logic         clk,
  input  cpuPkg::addrT addr,
  input  cpuPkg::dataT dataOut,
  input  logic         m1N,
  input  logic         rd,
  input  logic         wr,
  input  logic         iorq,
  input  int           readWaits,   // Tw count for each memory read
  output cpuPkg::dataT dataIn,
  output logic         waitN
);

  cpuPkg::dataT mem [0:(1 << `CPU_ADDR_W) - 1];
  cpuPkg::addrT ioAddrLog [0:15];
  cpuPkg::dataT ioDataLog [0:15];
  int           ioCount;
  int           waitLeft;
  logic         rdQ, wrQ;

  // All four address nibbles fold into values that run as NOP
  task automatic clearAll();
    for (int a = 0; a < (1 << `CPU_ADDR_W); a++)
      mem[a] = 8'((a ^ (a >> 4) ^ (a >> 8) ^ (a >> 12)) & 15);
    ioCount = 0;
  endtask

  task automatic clearLog();
    ioCount = 0;
  endtask

  task automatic loadByte(input cpuPkg::addrT a, input cpuPkg::dataT d);
    mem[a] = d;
  endtask

  initial
  begin
    dataIn   = '0;
    waitN    = 1'b1;
    ioCount  = 0;
    waitLeft = 0;
    rdQ      = 1'b0;
    wrQ      = 1'b0;
  end

  always @(negedge clk)
  begin
    dataIn = mem[addr];
    if (rd && !rdQ)
    begin
      waitLeft = m1N ? readWaits : 0;   // T1, not sampled by the core
      waitN    = 1'b1;
    end
    else if (waitLeft > 0)
    begin
      waitN    = 1'b0;
      waitLeft = waitLeft - 1;
    end
    else
      waitN = 1'b1;

    // Log once per I/O write, at T2
    if (iorq && wr && !wrQ && ioCount < 16)
    begin
      ioAddrLog[ioCount] = addr;
      ioDataLog[ioCount] = dataOut;
      ioCount            = ioCount + 1;
    end
    rdQ = rd;
    wrQ = wr;
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/busCycleIf.sv
verilog/busCycleSeq.sv
verilog/instrCtrl.sv
verilog/busArbiter.sv
verilog/cpuTop.sv
dv/memModel.sv
dv/cpuTb.sv

// ==== verilog/busArbiter.sv ====
//----------------------------------------------------------
// Bus grant for an external master. busRqN is registered
// once; the grant is taken only at a machine-cycle boundary.
//----------------------------------------------------------
`timescale 1ns/1ps

module busArbiter (
  input  logic clk,
  input  logic reset_n,
  input  logic busRqN,
  input  logic cycleEnd,
  output logic hold,
  output logic busAkN
);

  logic busRqS;     // Registered request, active high
  logic holdQ;      // Bus currently granted

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      busRqS <= 1'b0;
      holdQ  <= 1'b0;
    end
    else
    begin
      busRqS <= !busRqN;
      if (busRqS && cycleEnd)
        holdQ <= 1'b1;
      else if (!busRqS)
        holdQ <= 1'b0;  // Release one cycle after request drops
    end
  end

  // Sequencer must not start a cycle at the granting edge
  assign hold   = holdQ || (busRqS && cycleEnd);
  assign busAkN = !holdQ;

endmodule

// ==== verilog/busCycleIf.sv ====
//----------------------------------------------------------
// Request and completion handshake between the instruction
// controller and the T-state sequencer. A request is taken
// at the edge ending an idle or done cycle with req high.
//----------------------------------------------------------
`timescale 1ns/1ps

interface busCycleIf;

  logic              req;      // Next machine cycle wanted
  cpuPkg::cycleKindT kind;
  cpuPkg::addrT      addr;
  cpuPkg::dataT      wrData;   // Only used by I/O writes

  // One-cycle pulse in the final T-state
  logic              done;
  cpuPkg::dataT      rdData;   // Valid with done

  modport ctrl (
    output req,
    output kind,
    output addr,
    output wrData,
    input  done,
    input  rdData
  );

  modport seq (
    input  req,
    input  kind,
    input  addr,
    input  wrData,
    output done,
    output rdData
  );

endinterface

// ==== verilog/busCycleSeq.sv ====
//----------------------------------------------------------
// T-state sequencer. One T-state per clock, all strobes
// registered. waitN is sampled in T2 and Tw only. While hold
// is high the bus is parked with addr and dataOut at zero.
//----------------------------------------------------------
`timescale 1ns/1ps
`include "cpu_settings.svh"

module busCycleSeq (
  input  logic          clk,
  input  logic          reset_n,
  busCycleIf.seq        bus,
  input  logic          hold,
  output logic          cycleEnd,
  input  logic          waitN,
  input  cpuPkg::dataT  dataIn,
  output cpuPkg::addrT  addr,
  output cpuPkg::dataT  dataOut,
  output logic          m1N,
  output logic          rfshN,
  output logic          rd,
  output logic          wr,
  output logic          iorq
);

  cpuPkg::tStateT    tState, nxtT;
  cpuPkg::cycleKindT kindQ, nxtKind;
  cpuPkg::addrT      addrQ, nxtAddr;
  cpuPkg::dataT      wrDataQ, nxtData;
  cpuPkg::dataT      opLatch;             // Opcode held from T2 to T4
  logic [3:0]        ioWaitCnt;
  logic [`CPU_RFSH_W-1:0] rfshCnt;
  logic              finalT, startNew, stretch;
  logic              earlyT, rfshT;

  // Last T-state of the current machine cycle
  assign finalT   = (tState == cpuPkg::t4) ||
                    (tState == cpuPkg::t3 && kindQ != cpuPkg::fetch);
  assign startNew = bus.req && !hold && (finalT || tState == cpuPkg::idle);
  assign stretch  = (ioWaitCnt != 4'd0) || !waitN;

  assign cycleEnd   = finalT || (tState == cpuPkg::idle);
  assign bus.done   = finalT;
  assign bus.rdData = (kindQ == cpuPkg::fetch) ? opLatch : dataIn;

  //----------------------------------------------------------
  // Next T-state
  //----------------------------------------------------------
  always_comb
  begin
    nxtKind = startNew ? bus.kind : kindQ;
    nxtAddr = startNew ? bus.addr : addrQ;
    nxtData = startNew ? bus.wrData : wrDataQ;
    case (tState)
      cpuPkg::t1:               nxtT = cpuPkg::t2;
      cpuPkg::t2, cpuPkg::tw:   nxtT = stretch ? cpuPkg::tw : cpuPkg::t3;
      cpuPkg::t3:
      begin
        if (kindQ == cpuPkg::fetch)
          nxtT = cpuPkg::t4;
        else
          nxtT = startNew ? cpuPkg::t1 : cpuPkg::idle;
      end
      default:                  nxtT = startNew ? cpuPkg::t1 : cpuPkg::idle;
    endcase
  end

  assign earlyT = nxtT inside {cpuPkg::t1, cpuPkg::t2, cpuPkg::tw};
  assign rfshT  = (nxtKind == cpuPkg::fetch) && (nxtT inside {cpuPkg::t3, cpuPkg::t4});

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tState    <= cpuPkg::idle;
      kindQ     <= cpuPkg::fetch;
      ioWaitCnt <= 4'd0;
      rfshCnt   <= '0;
      m1N       <= 1'b1;
      rfshN     <= 1'b1;
      rd        <= 1'b0;
      wr        <= 1'b0;
      iorq      <= 1'b0;
      addr      <= '0;
      dataOut   <= '0;
    end
    else
    begin
      tState <= nxtT;
      kindQ  <= nxtKind;
      if (startNew)
        ioWaitCnt <= (bus.kind == cpuPkg::ioWrite) ? 4'(`CPU_IO_WAITS) : 4'd0;
      else if ((tState == cpuPkg::t2 || tState == cpuPkg::tw) && ioWaitCnt != 4'd0)
        ioWaitCnt <= ioWaitCnt - 4'd1;
      if (tState == cpuPkg::t4)
        rfshCnt <= rfshCnt + 1'b1;      // Advance after each refresh

      m1N   <= !(earlyT && nxtKind == cpuPkg::fetch);
      rd    <= earlyT && nxtKind != cpuPkg::ioWrite;
      rfshN <= !rfshT;
      wr    <= (nxtKind == cpuPkg::ioWrite) && (nxtT inside {cpuPkg::t2, cpuPkg::tw, cpuPkg::t3});
      iorq  <= (nxtKind == cpuPkg::ioWrite) && (nxtT inside {cpuPkg::t2, cpuPkg::tw, cpuPkg::t3});

      // Address mux, refresh address in fetch T3/T4
      if (nxtT == cpuPkg::idle)
        addr <= '0;
      else if (rfshT)
        addr <= {{(`CPU_ADDR_W-`CPU_RFSH_W){1'b0}}, rfshCnt};
      else
        addr <= nxtAddr;
      dataOut <= (nxtKind == cpuPkg::ioWrite && nxtT != cpuPkg::idle) ? nxtData : '0;
    end
  end

  // Request payload and fetched opcode
  always_ff @(posedge clk)
  begin
    addrQ   <= nxtAddr;
    wrDataQ <= nxtData;
    if ((tState == cpuPkg::t2 || tState == cpuPkg::tw) && !stretch && kindQ == cpuPkg::fetch)
      opLatch <= dataIn;
  end

endmodule

// ==== verilog/cpuPkg.sv ====
//----------------------------------------------------------
// Types shared by the bus-cycle engine and its controller.
// Only the five opcodes listed here are decoded.
//----------------------------------------------------------
`include "cpu_settings.svh"

package cpuPkg;

  typedef logic [`CPU_ADDR_W-1:0] addrT;
  typedef logic [`CPU_DATA_W-1:0] dataT;

  // Kinds of machine cycle the sequencer can run
  typedef enum logic [1:0] {
    fetch,
    memRead,
    ioWrite
  } cycleKindT;

  typedef enum logic [2:0] {
    idle,
    t1,
    t2,
    tw,     // Wait state, requested or automatic
    t3,
    t4      // Fetch only
  } tStateT;

  typedef enum logic [2:0] {
    fetchOp,
    readLow,    // JP operand, low byte
    readHigh,
    readN,      // Immediate of LD A,n or port of OUT
    ioOut,
    halted
  } execStateT;

  //----------------------------------------------------------
  // Opcodes
  //----------------------------------------------------------
  localparam dataT opNop   = 8'h00;
  localparam dataT opLdAN  = 8'h3E;
  localparam dataT opJp    = 8'hC3;
  localparam dataT opOut   = 8'hD3;
  localparam dataT opHalt  = 8'h76;

endpackage

// ==== verilog/cpuTop.sv ====
//----------------------------------------------------------
// Core top level. Outputs are never tri-stated; during a
// bus grant addr and dataOut are driven to zero.
//----------------------------------------------------------
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpuTop (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   waitN,
  input  logic                   busRqN,
  input  logic [`CPU_DATA_W-1:0] dataIn,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic [`CPU_DATA_W-1:0] dataOut,
  output logic                   m1N,
  output logic                   rfshN,
  output logic                   rd,
  output logic                   wr,
  output logic                   iorq,
  output logic                   haltN,
  output logic                   busAkN
);

  logic hold;
  logic cycleEnd;

  busCycleIf cycBus ();

  instrCtrl instrCtrl_i (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (cycBus.ctrl),
    .haltN   (haltN)
  );

  busCycleSeq busCycleSeq_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus      (cycBus.seq),
    .hold     (hold),
    .cycleEnd (cycleEnd),
    .waitN    (waitN),
    .dataIn   (dataIn),
    .addr     (addr),
    .dataOut  (dataOut),
    .m1N      (m1N),
    .rfshN    (rfshN),
    .rd       (rd),
    .wr       (wr),
    .iorq     (iorq)
  );

  busArbiter busArbiter_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .busRqN   (busRqN),
    .cycleEnd (cycleEnd),
    .hold     (hold),
    .busAkN   (busAkN)
  );

endmodule

// ==== verilog/cpu_settings.svh ====
//----------------------------------------------------------
// Bus widths and timing constants of the core.
// The I/O address is built as (A, n), so CPU_ADDR_W must
// be twice CPU_DATA_W. CPU_IO_WAITS must stay below 16.
//----------------------------------------------------------
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_ADDR_W   16      // External address bus
`define CPU_DATA_W   8       // External data bus

// First opcode fetch after reset
`define CPU_RESET_PC 'h0000

`define CPU_IO_WAITS 1       // Automatic Tw in I/O cycles
`define CPU_RFSH_W   7       // Refresh counter, low address bits

`endif

// ==== verilog/instrCtrl.sv ====
//----------------------------------------------------------
// Instruction controller. Decodes NOP, LD A,n, JP nn,
// OUT (n),A and HALT; anything else runs as NOP. HALT is
// left only through reset. The request always names the
// cycle that follows, so cycles run back to back.
//----------------------------------------------------------
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instrCtrl (
  input  logic    clk,
  input  logic    reset_n,
  busCycleIf.ctrl bus,
  output logic    haltN
);

  cpuPkg::execStateT state, nxtState;
  cpuPkg::addrT      pc, nxtPc;
  cpuPkg::dataT      ir, nxtIr;
  cpuPkg::dataT      acc, nxtAcc;
  cpuPkg::dataT      opLow, nxtOpLow;     // Operand byte

  //----------------------------------------------------------
  // Execution step, advances only on done
  //----------------------------------------------------------
  always_comb
  begin
    nxtState = state;
    nxtPc    = pc;
    nxtIr    = ir;
    nxtAcc   = acc;
    nxtOpLow = opLow;
    if (bus.done)
    begin
      case (state)
        cpuPkg::fetchOp:
        begin
          nxtIr = bus.rdData;
          nxtPc = pc + 1'b1;
          case (bus.rdData)
            cpuPkg::opNop:  nxtState = cpuPkg::fetchOp;
            cpuPkg::opLdAN: nxtState = cpuPkg::readN;
            cpuPkg::opOut:  nxtState = cpuPkg::readN;
            cpuPkg::opJp:   nxtState = cpuPkg::readLow;
            cpuPkg::opHalt: nxtState = cpuPkg::halted;
            default:        nxtState = cpuPkg::fetchOp;   // Unsupported
          endcase
        end
        cpuPkg::readN:
        begin
          nxtPc = pc + 1'b1;
          if (ir == cpuPkg::opOut)
          begin
            nxtOpLow = bus.rdData;              // Port number
            nxtState = cpuPkg::ioOut;
          end
          else
          begin
            nxtAcc   = bus.rdData;
            nxtState = cpuPkg::fetchOp;
          end
        end
        cpuPkg::readLow:
        begin
          nxtOpLow = bus.rdData;
          nxtPc    = pc + 1'b1;
          nxtState = cpuPkg::readHigh;
        end
        cpuPkg::readHigh:
        begin
          nxtPc    = {bus.rdData, opLow};       // Jump target
          nxtState = cpuPkg::fetchOp;
        end
        cpuPkg::ioOut:   nxtState = cpuPkg::fetchOp;
        default:         nxtState = cpuPkg::halted;  // Refetch, PC frozen
      endcase
    end
  end

  // Core always has another cycle to run
  assign bus.req    = 1'b1;
  assign bus.wrData = nxtAcc;

  always_comb
  begin
    bus.kind = cpuPkg::memRead;
    bus.addr = nxtPc;
    case (nxtState)
      cpuPkg::fetchOp, cpuPkg::halted: bus.kind = cpuPkg::fetch;
      cpuPkg::ioOut:
      begin
        bus.kind = cpuPkg::ioWrite;
        bus.addr = {nxtAcc, nxtOpLow};          // A on the upper byte
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= cpuPkg::fetchOp;
      pc    <= cpuPkg::addrT'(`CPU_RESET_PC);
      haltN <= 1'b1;
    end
    else
    begin
      state <= nxtState;
      pc    <= nxtPc;
      haltN <= (nxtState != cpuPkg::halted);  // Falls at end of HALT fetch
    end
  end

  always_ff @(posedge clk)
  begin
    ir    <= nxtIr;
    acc   <= nxtAcc;
    opLow <= nxtOpLow;
  end

endmodule
